/* hdl/fixed_vec_pkg.sv */
`default_nettype none

// signed q8.8 number format and the point record moved between pipeline stages
package fixed_vec_pkg;

    localparam int frac_bits = 8;                   // q8.8, low byte is fraction
    localparam int coord_w   = 16;                  // one coordinate word

    typedef logic signed [coord_w-1:0] coord_t;     // signed q8.8 coordinate

    localparam coord_t coord_max = 16'sh7fff;       // +127.996
    localparam coord_t coord_min = 16'sh8000;       // -128.0

    typedef struct packed {
        coord_t x;                                  // msb word
        coord_t y;
        coord_t z;                                  // lsb word
    } vec3_t;

    typedef struct packed {
        logic  valid;                               // point present this cycle
        vec3_t vec;                                 // payload
    } point_t;

    localparam int scale_latency     = 2;           // product reg + round/sat reg
    localparam int translate_latency = 1;           // single sum reg

endpackage

`default_nettype wire

/* hdl/point_transform.sv */
`default_nettype none
`timescale 1ns/1ps

// streaming point transform, out = in * scale + trans
// 3 cycles from input sample to output, one point per cycle
module point_transform (
    input  wire                        clk,
    input  wire                        reset,
    input  xform_regmap_pkg::apb_req_t apb,
    output logic [15:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  fixed_vec_pkg::point_t      in_point,
    output fixed_vec_pkg::point_t      out_point
);

    fixed_vec_pkg::vec3_t  scale_vec;               // from config regs
    fixed_vec_pkg::vec3_t  trans_vec;               // from config regs
    fixed_vec_pkg::point_t scaled_point;            // scale -> translate

    transform_regs transform_regs_inst (
        .clk       (clk),
        .reset     (reset),
        .apb       (apb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .scale_vec (scale_vec),
        .trans_vec (trans_vec)
    );

    // 2 cycles
    scale_stage scale_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .in_point  (in_point),
        .scale_vec (scale_vec),
        .out_point (scaled_point)
    );

    // 1 cycle
    translate_stage translate_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .in_point  (scaled_point),
        .trans_vec (trans_vec),
        .out_point (out_point)
    );

endmodule

`default_nettype wire

/* hdl/scale_stage.sv */
`default_nettype none
`timescale 1ns/1ps

// elementwise q8.8 multiply, 2 cycles
// stage 1 holds the raw products, stage 2 the rounded and clamped result
module scale_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  fixed_vec_pkg::point_t in_point,
    input  fixed_vec_pkg::vec3_t  scale_vec,
    output fixed_vec_pkg::point_t out_point
);

    localparam int prod_w   = 2 * fixed_vec_pkg::coord_w;          // full product, q16.16
    localparam int half_lsb = 1 << (fixed_vec_pkg::frac_bits - 1); // 0.5 lsb after shift
    localparam int last     = fixed_vec_pkg::scale_latency - 1;

    typedef struct packed {
        logic signed [prod_w-1:0] x;
        logic signed [prod_w-1:0] y;
        logic signed [prod_w-1:0] z;
    } prod3_t;

    prod3_t                  prod;                  // stage 1 payload
    fixed_vec_pkg::vec3_t    res;                   // stage 2 payload
    logic [last:0]           valid_pipe;            // valid delay line, one bit per stage

    // round to nearest, back to q8.8, clamp to coord range
    function automatic fixed_vec_pkg::coord_t round_sat(input logic signed [prod_w-1:0] p);
        logic signed [prod_w-1:0] r;
        r = (p + half_lsb) >>> fixed_vec_pkg::frac_bits;
        if (r > fixed_vec_pkg::coord_max)
            return fixed_vec_pkg::coord_max;
        else if (r < fixed_vec_pkg::coord_min)
            return fixed_vec_pkg::coord_min;
        else
            return r[fixed_vec_pkg::coord_w-1:0];   // fits, drop sign extension
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[last-1:0], in_point.valid};
        end
    end

    // datapath regs, qualified by valid_pipe
    always_ff @(posedge clk) begin
        prod.x <= in_point.vec.x * scale_vec.x;     // signed 16x16
        prod.y <= in_point.vec.y * scale_vec.y;
        prod.z <= in_point.vec.z * scale_vec.z;
        res.x  <= round_sat(prod.x);
        res.y  <= round_sat(prod.y);
        res.z  <= round_sat(prod.z);
    end

    assign out_point.valid = valid_pipe[last];
    assign out_point.vec   = res;

endmodule

`default_nettype wire

/* hdl/transform_regs.sv */
`default_nettype none
`timescale 1ns/1ps

// apb slave with the per-axis scale and translate vectors
module transform_regs (
    input  wire                        clk,
    input  wire                        reset,
    input  xform_regmap_pkg::apb_req_t apb,
    output logic [15:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output fixed_vec_pkg::vec3_t       scale_vec,
    output fixed_vec_pkg::vec3_t       trans_vec
);

    logic        access;                            // access phase of a transfer
    logic        hit;                               // address maps to a register
    logic [15:0] rd_data;                           // selected register, 0 if unmapped

    assign access = apb.psel && apb.penable;

    // address decode, shared by read mux and error flag
    always_comb begin
        hit     = 1'b1;
        rd_data = '0;
        case (apb.paddr)
            xform_regmap_pkg::scale_x_addr: rd_data = scale_vec.x;
            xform_regmap_pkg::scale_y_addr: rd_data = scale_vec.y;
            xform_regmap_pkg::scale_z_addr: rd_data = scale_vec.z;
            xform_regmap_pkg::trans_x_addr: rd_data = trans_vec.x;
            xform_regmap_pkg::trans_y_addr: rd_data = trans_vec.y;
            xform_regmap_pkg::trans_z_addr: rd_data = trans_vec.z;
            default: begin
                hit     = 1'b0;                     // unmapped
                rd_data = '0;
            end
        endcase
    end

    assign pready  = 1'b1;                          // zero wait states
    assign pslverr = access && !hit;
    assign prdata  = (access && !apb.pwrite) ? rd_data : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            scale_vec.x <= xform_regmap_pkg::scale_reset;
            scale_vec.y <= xform_regmap_pkg::scale_reset;
            scale_vec.z <= xform_regmap_pkg::scale_reset;
            trans_vec.x <= xform_regmap_pkg::trans_reset;
            trans_vec.y <= xform_regmap_pkg::trans_reset;
            trans_vec.z <= xform_regmap_pkg::trans_reset;
        end else if (access && apb.pwrite) begin
            case (apb.paddr)
                xform_regmap_pkg::scale_x_addr: scale_vec.x <= apb.pwdata;
                xform_regmap_pkg::scale_y_addr: scale_vec.y <= apb.pwdata;
                xform_regmap_pkg::scale_z_addr: scale_vec.z <= apb.pwdata;
                xform_regmap_pkg::trans_x_addr: trans_vec.x <= apb.pwdata;
                xform_regmap_pkg::trans_y_addr: trans_vec.y <= apb.pwdata;
                xform_regmap_pkg::trans_z_addr: trans_vec.z <= apb.pwdata;
                default: ;                          // bad address, pslverr only
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/translate_stage.sv */
`default_nettype none
`timescale 1ns/1ps

// elementwise saturating add, 1 cycle
module translate_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  fixed_vec_pkg::point_t in_point,
    input  fixed_vec_pkg::vec3_t  trans_vec,
    output fixed_vec_pkg::point_t out_point
);

    localparam int sum_w = fixed_vec_pkg::coord_w + 1;  // one guard bit

    logic                 valid_q;
    fixed_vec_pkg::vec3_t sum_q;

    // overflow when the guard bit and the coord sign bit disagree
    function automatic fixed_vec_pkg::coord_t sat_add(input fixed_vec_pkg::coord_t a,
                                                      input fixed_vec_pkg::coord_t b);
        logic signed [sum_w-1:0] s;
        s = a + b;                                  // sign extended to 17 bits
        if (s[sum_w-1] != s[sum_w-2])
            return s[sum_w-1] ? fixed_vec_pkg::coord_min : fixed_vec_pkg::coord_max;
        else
            return s[sum_w-2:0];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_point.valid;
        end
    end

    always_ff @(posedge clk) begin
        sum_q.x <= sat_add(in_point.vec.x, trans_vec.x);
        sum_q.y <= sat_add(in_point.vec.y, trans_vec.y);
        sum_q.z <= sat_add(in_point.vec.z, trans_vec.z);
    end

    assign out_point.valid = valid_q;
    assign out_point.vec   = sum_q;

endmodule

`default_nettype wire

/* hdl/xform_regmap_pkg.sv */
`default_nettype none

// apb register map of the transform configuration block
package xform_regmap_pkg;

    localparam int addr_w = 8;                      // byte address, word aligned regs

    localparam logic [addr_w-1:0] scale_x_addr = 8'h00;
    localparam logic [addr_w-1:0] scale_y_addr = 8'h04;
    localparam logic [addr_w-1:0] scale_z_addr = 8'h08;
    localparam logic [addr_w-1:0] trans_x_addr = 8'h0c;
    localparam logic [addr_w-1:0] trans_y_addr = 8'h10;
    localparam logic [addr_w-1:0] trans_z_addr = 8'h14;

    localparam logic [15:0] scale_reset = 16'h0100; // 1.0 in q8.8
    localparam logic [15:0] trans_reset = 16'h0000; // no offset

    typedef struct packed {
        logic              psel;                    // slave selected
        logic              penable;                 // access phase
        logic              pwrite;                  // 1 write, 0 read
        logic [addr_w-1:0] paddr;
        logic [15:0]       pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

/* project.f */
hdl/fixed_vec_pkg.sv
hdl/xform_regmap_pkg.sv
hdl/transform_regs.sv
hdl/scale_stage.sv
hdl/translate_stage.sv
hdl/point_transform.sv
verification/transform_checker.sv
verification/tb_point_transform.sv

/* verification/tb_point_transform.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_point_transform;

    localparam int n_identity = 20;
    localparam int n_random   = 200;
    localparam int max_gap    = 3;                  // idle cycles after a random point
    localparam int n_sat      = 16;                 // two passes of 8
    localparam int n_b2b      = 50;
    localparam int n_apb      = 60;                 // bound on accesses over all tests
    // points with their gaps, 3 cycles per access, drain per test, reset; doubled
    localparam int n_cycles   = n_identity + n_random * (1 + max_gap) + n_sat + n_b2b;
    localparam int cycle_limit = 2 * (n_cycles + 3 * n_apb + 8 * (3 + 2) + 4);

    logic                       clk;
    logic                       reset;
    xform_regmap_pkg::apb_req_t apb;
    logic [15:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    fixed_vec_pkg::point_t      in_point;
    fixed_vec_pkg::point_t      out_point;
    logic [31:0]                rng_state;
    int                         cycle_count;

    point_transform point_transform_inst (
        .clk       (clk),
        .reset     (reset),
        .apb       (apb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_point  (in_point),
        .out_point (out_point)
    );

    transform_checker transform_checker_inst (
        .clk       (clk),
        .reset     (reset),
        .apb       (apb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_point  (in_point),
        .out_point (out_point)
    );

    always #50 clk = ~clk;                          // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // xorshift32
    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function fixed_vec_pkg::vec3_t random_vec();
        fixed_vec_pkg::vec3_t v;
        v.x = 16'(next_random());
        v.y = 16'(next_random());
        v.z = 16'(next_random());
        return v;
    endfunction

    // corner values for the clamp test
    function logic [15:0] extreme(input int i);
        case (i % 8)
            0: return 16'h7fff;
            1: return 16'h8000;
            2: return 16'h4000;
            3: return 16'hc000;
            4: return 16'h0100;
            5: return 16'hff00;
            6: return 16'h0001;
            default: return 16'hffff;
        endcase
    endfunction

    task apb_access(input logic write, input logic [7:0] addr, input logic [15:0] data);
        @(negedge clk);
        apb.psel    = 1'b1;                         // setup phase
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;                         // access phase, checker samples here
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task read_all();
        for (int i = 0; i < 6; i++)
            apb_access(1'b0, 8'(4 * i), 16'h0000);
    endtask

    task write_random_regs();
        for (int i = 0; i < 6; i++)
            apb_access(1'b1, 8'(4 * i), 16'(next_random()));
    endtask

    task write_uniform(input logic [15:0] scale, input logic [15:0] trans);
        for (int i = 0; i < 3; i++) begin
            apb_access(1'b1, 8'(4 * i), scale);     // scale x,y,z
            apb_access(1'b1, 8'(4 * i + 12), trans);
        end
    endtask

    task drive_point(input fixed_vec_pkg::vec3_t v);
        @(negedge clk);
        in_point.valid = 1'b1;
        in_point.vec   = v;
    endtask

    task send_points(input int n, input int gap_max);
        int gap;
        for (int i = 0; i < n; i++) begin
            drive_point(random_vec());
            gap = (gap_max > 0) ? int'(next_random() % (gap_max + 1)) : 0;
            repeat (gap) begin
                @(negedge clk);
                in_point.valid = 1'b0;
            end
        end
        @(negedge clk);
        in_point.valid = 1'b0;
    endtask

    task wait_drain();
        while (transform_checker_inst.pending_points() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    task saturation_pass(input logic [15:0] scale, input logic [15:0] trans);
        fixed_vec_pkg::vec3_t v;
        write_uniform(scale, trans);
        for (int i = 0; i < n_sat / 2; i++) begin
            v.x = extreme(i);
            v.y = extreme(i + 3);
            v.z = extreme(i + 5);
            drive_point(v);
        end
        @(negedge clk);
        in_point.valid = 1'b0;
        wait_drain();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        apb         = '0;
        in_point    = '0;
        rng_state   = 32'h3e0e_76a0;
        cycle_count = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        transform_checker_inst.start_test("reset_identity");
        send_points(n_identity, 1);
        wait_drain();
        transform_checker_inst.finish_test();

        transform_checker_inst.start_test("reg_readback");
        read_all();                                 // reset values first
        write_random_regs();
        read_all();
        transform_checker_inst.finish_test();

        transform_checker_inst.start_test("bad_address");
        apb_access(1'b1, 8'h18, 16'(next_random()));    // just past the map
        apb_access(1'b0, 8'h18, 16'h0000);
        apb_access(1'b1, 8'h02, 16'(next_random()));    // misaligned
        apb_access(1'b0, 8'hfc, 16'h0000);
        read_all();                                 // nothing may have moved
        transform_checker_inst.finish_test();

        transform_checker_inst.start_test("random_transform");
        write_random_regs();
        send_points(n_random, max_gap);
        wait_drain();
        transform_checker_inst.finish_test();

        transform_checker_inst.start_test("saturation");
        saturation_pass(16'h7fff, 16'h7fff);        // push toward coord_max
        saturation_pass(16'h8000, 16'h8000);        // -128 scale and offset
        transform_checker_inst.finish_test();

        transform_checker_inst.start_test("back_to_back");
        write_random_regs();
        send_points(n_b2b, 0);
        wait_drain();
        transform_checker_inst.finish_test();

        transform_checker_inst.print_summary();
        if (transform_checker_inst.fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/transform_checker.sv */
`default_nettype none
`timescale 1ns/1ps

// watches the dut pins and keeps its own copy of the config regs from apb traffic
// to predict every output point with plain integer arithmetic
module transform_checker (
    input wire                        clk,
    input wire                        reset,
    input xform_regmap_pkg::apb_req_t apb,
    input wire [15:0]                 prdata,
    input wire                        pready,
    input wire                        pslverr,
    input fixed_vec_pkg::point_t      in_point,
    input fixed_vec_pkg::point_t      out_point
);

    localparam int exp_latency = 3;                 // input edge to output edge

    logic [15:0]          regs [6];                 // scale x,y,z then trans x,y,z
    fixed_vec_pkg::vec3_t exp_q [$];                // predicted outputs in arrival order
    int                   stamp_q [$];              // edge number of each input
    int                   edge_count;
    int                   check_count = 0;
    int                   fail_count = 0;
    int                   point_count = 0;
    int                   access_count = 0;
    int                   test_fails = 0;           // fail_count when the test began
    string                test_name = "startup";

    function automatic int reg_index(input logic [xform_regmap_pkg::addr_w-1:0] addr);
        case (addr)
            xform_regmap_pkg::scale_x_addr: return 0;
            xform_regmap_pkg::scale_y_addr: return 1;
            xform_regmap_pkg::scale_z_addr: return 2;
            xform_regmap_pkg::trans_x_addr: return 3;
            xform_regmap_pkg::trans_y_addr: return 4;
            xform_regmap_pkg::trans_z_addr: return 5;
            default: return -1;                     // unmapped
        endcase
    endfunction

    function automatic int clamp(input int v);
        if (v > 32767)
            return 32767;                           // +127.996
        if (v < -32768)
            return -32768;                          // -128.0
        return v;
    endfunction

    // q16.16 product plus 128 then >>>8 rounds half up
    function automatic int scale_axis(input int a, input int s);
        return clamp((a * s + 128) >>> 8);
    endfunction

    function automatic fixed_vec_pkg::vec3_t model(input fixed_vec_pkg::vec3_t v);
        fixed_vec_pkg::vec3_t r;
        r.x = 16'(clamp(scale_axis(v.x, $signed(regs[0])) + $signed(regs[3])));
        r.y = 16'(clamp(scale_axis(v.y, $signed(regs[1])) + $signed(regs[4])));
        r.z = 16'(clamp(scale_axis(v.z, $signed(regs[2])) + $signed(regs[5])));
        return r;
    endfunction

    function int pending_points();
        return exp_q.size();
    endfunction

    task start_test(input string name);
        test_name  = name;
        test_fails = fail_count;
    endtask

    task finish_test();
        $display("test %s finished, %0d mismatches", test_name, fail_count - test_fails);
    endtask

    task print_summary();
        $display("points %0d, apb accesses %0d, checks %0d, failures %0d",
                 point_count, access_count, check_count, fail_count);
    endtask

    task fail_value(input string what, input logic [47:0] exp, input logic [47:0] act);
        fail_count++;
        $display("Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task fail_msg(input string msg);
        fail_count++;
        $display("%s: %s", test_name, msg);
    endtask

    always @(posedge clk) begin
        int                   idx;
        int                   lat;
        logic [15:0]          exp_rd;
        fixed_vec_pkg::vec3_t exp_v;
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                regs[i]     = 16'h0100;                         // 1.0
                regs[i + 3] = 16'h0000;                         // no offset
            end
            exp_q.delete();
            stamp_q.delete();
            edge_count = 0;
        end else begin
            edge_count++;
            // output side first since it belongs to older inputs
            if (out_point.valid) begin
                check_count++;
                if (exp_q.size() == 0) begin
                    fail_msg("output appeared with no point in flight");
                end else begin
                    exp_v = exp_q.pop_front();
                    lat   = edge_count - stamp_q.pop_front();
                    if (lat != exp_latency)
                        fail_value("latency", exp_latency, lat);
                    if (out_point.vec !== exp_v)
                        fail_value("point", exp_v, out_point.vec);
                end
            end else if (exp_q.size() != 0 && edge_count - stamp_q[0] >= exp_latency) begin
                check_count++;
                fail_msg("expected output point did not appear");
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
            if (in_point.valid) begin
                point_count++;
                exp_q.push_back(model(in_point.vec));       // regs as they stand now
                stamp_q.push_back(edge_count);
            end
            // apb access phase
            if (apb.psel && apb.penable) begin
                access_count++;
                check_count++;
                idx = reg_index(apb.paddr);
                if (!pready)
                    fail_msg("pready low during an access");
                if (pslverr !== (idx < 0))
                    fail_value($sformatf("pslverr at 0x%02h", apb.paddr), idx < 0, pslverr);
                if (!apb.pwrite || idx < 0) begin
                    exp_rd = (idx < 0) ? 16'h0000 : regs[idx];  // unmapped reads as 0
                    if (prdata !== exp_rd)
                        fail_value($sformatf("prdata at 0x%02h", apb.paddr), exp_rd, prdata);
                end else begin
                    regs[idx] = apb.pwdata;
                end
            end else if (pslverr !== 1'b0) begin
                fail_msg("pslverr high with no apb access in progress");
            end
        end
    end

endmodule

`default_nettype wire
